// ==== design/accel_isa_pkg.sv ====
`default_nettype none

package accel_isa_pkg;

    // instruction word and field widths
    parameter int INST_W        = 32;
    parameter int LDST_RF_W     = 9;
    parameter int SDRAM_FIELD_W = 13;
    parameter int EU_UNIT_W     = 5;
    parameter int FETCH_FIELD_W = 24;

    // top two bits of every instruction
    typedef enum logic [1:0] {
        OP_LOAD       = 2'b00,
        OP_STORE      = 2'b01,
        OP_MOVE       = 2'b10,
        OP_FETCH_EXEC = 2'b11
    } op_t;

    // function bit of the fetch/exec format
    typedef enum logic {
        EU_FETCH = 1'b0,
        EU_EXEC  = 1'b1
    } eu_fun_t;

endpackage

`default_nettype wire

// ==== design/accel_ctrl_pkg.sv ====
`default_nettype none

package accel_ctrl_pkg;

    // width of any line count
    parameter int LINE_W = 8;

    // sequencer states
    typedef enum logic [2:0] {
        IDLE_REQ,
        WAIT_ACK,
        RELEASE,
        DISPATCH,
        RUN_LDST,
        RUN_MOVE,
        EU_REQ,
        EU_RELEASE
    } seq_state_t;

endpackage

`default_nettype wire

// ==== design/inst_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module inst_decode #(
    parameter int RF_ADDR_W = 10,
    parameter logic [14:0] SDRAM_OFFSET = 15'h1000
) (
    input wire [accel_isa_pkg::INST_W-1:0] inst,

    output logic load,
    output logic store,
    output logic move,
    output logic fetch,
    output logic exec,

    // toward the load/store engine
    output logic [RF_ADDR_W-1:0]             ldst_rf_addr,
    output logic [31:0]                      ldst_sdram_addr,
    output logic [accel_ctrl_pkg::LINE_W-1:0] ldst_line_num,

    // toward the register-file mover
    output logic [RF_ADDR_W-1:0]             move_src_addr,
    output logic [RF_ADDR_W-1:0]             move_dst_addr,
    output logic [accel_ctrl_pkg::LINE_W-1:0] move_line_num,
    output logic                             move_src_freeze,
    output logic                             move_dst_freeze,

    // toward the execution units
    output logic [accel_isa_pkg::EU_UNIT_W-1:0] eu_unit,
    output logic [31:0]                         eu_fetch_addr
);
    import accel_isa_pkg::*;
    import accel_ctrl_pkg::*;

    op_t     inst_op;
    eu_fun_t inst_fun;

    // opcode and function bit sit at the top of the word
    assign inst_op  = op_t'(inst[INST_W-1 -: 2]);
    assign inst_fun = eu_fun_t'(inst[INST_W-3]);

    // load/store: rf[29:21] sdram[20:8] lines[7:0]
    assign ldst_rf_addr    = RF_ADDR_W'(inst[INST_W-3 -: LDST_RF_W]);
    // offset, line index, then 16-byte line stride
    assign ldst_sdram_addr = {SDRAM_OFFSET, inst[LINE_W +: SDRAM_FIELD_W], 4'b0000};
    assign ldst_line_num   = inst[LINE_W-1:0];

    // move: src[29:20] dst[19:10] freeze[9:8] lines[7:0]
    assign move_src_addr   = RF_ADDR_W'(inst[29:20]);
    assign move_dst_addr   = RF_ADDR_W'(inst[19:10]);
    assign move_src_freeze = inst[9];
    assign move_dst_freeze = inst[8];
    assign move_line_num   = inst[LINE_W-1:0];

    // fetch/exec: fun[29] unit[28:24] addr[23:0]
    assign eu_unit       = inst[FETCH_FIELD_W +: EU_UNIT_W];
    assign eu_fetch_addr = {4'b0000, inst[FETCH_FIELD_W-1:0], 4'b0000};

    // one strobe per instruction
    always_comb begin
        load  = 1'b0;
        store = 1'b0;
        move  = 1'b0;
        fetch = 1'b0;
        exec  = 1'b0;
        case (inst_op)
            OP_LOAD:  load  = 1'b1;
            OP_STORE: store = 1'b1;
            OP_MOVE:  move  = 1'b1;
            OP_FETCH_EXEC: begin
                // function bit picks fetch or exec
                if (inst_fun == EU_EXEC)
                    exec = 1'b1;
                else
                    fetch = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/issue_fsm.sv ====
`timescale 1ns/10ps
`default_nettype none

module issue_fsm (
    input wire clk,
    input wire reset,

    // instruction handshake
    output logic                              inst_req,
    input wire                                inst_ack,
    input wire [accel_isa_pkg::INST_W-1:0]    inst_data,
    output logic [accel_isa_pkg::INST_W-1:0]  inst_word,

    // decoded view of inst_word
    input wire                                load,
    input wire                                store,
    input wire                                move,
    input wire                                fetch,
    input wire                                exec,
    input wire [accel_ctrl_pkg::LINE_W-1:0]   ldst_line_num,
    input wire [accel_ctrl_pkg::LINE_W-1:0]   move_line_num,

    // engines and line counter
    input wire                                cnt_zero,
    input wire                                ldst_busy,
    input wire                                move_busy,
    output logic                              ldst_start,
    output logic                              ldst_we,
    output logic                              move_start,
    output logic                              cnt_load,
    output logic [accel_ctrl_pkg::LINE_W-1:0] cnt_init,

    // execution-unit handshake
    output logic                              eu_req,
    input wire                                eu_ack,
    output accel_isa_pkg::eu_fun_t            eu_fun,

    output logic busy
);
    import accel_isa_pkg::*;
    import accel_ctrl_pkg::*;

    seq_state_t state, state_next;

    always_ff @(posedge clk) begin
        if (reset)
            state <= IDLE_REQ;
        else
            state <= state_next;
    end

    // instruction register, held until the operation ends
    always_ff @(posedge clk) begin
        if (state == WAIT_ACK && inst_ack)
            inst_word <= inst_data;
        // function latched once for the whole eu handshake
        if (state == DISPATCH && (fetch || exec))
            eu_fun <= exec ? EU_EXEC : EU_FETCH;
    end

    always_comb begin
        state_next = state;
        case (state)
            // only raise req once the source has dropped ack
            IDLE_REQ:   if (!inst_ack) state_next = WAIT_ACK;
            WAIT_ACK:   if (inst_ack) state_next = RELEASE;
            RELEASE:    if (!inst_ack) state_next = DISPATCH;
            DISPATCH: begin
                if (load || store)
                    state_next = RUN_LDST;
                else if (move)
                    state_next = RUN_MOVE;
                else if (!eu_ack)
                    state_next = EU_REQ;
            end
            // engines stop on their own once the count runs out
            RUN_LDST:   if (cnt_zero && !ldst_busy) state_next = IDLE_REQ;
            RUN_MOVE:   if (cnt_zero && !move_busy) state_next = IDLE_REQ;
            EU_REQ:     if (eu_ack) state_next = EU_RELEASE;
            EU_RELEASE: if (!eu_ack) state_next = IDLE_REQ;
            default:    state_next = IDLE_REQ;
        endcase
    end

    assign inst_req = (state == WAIT_ACK);
    assign eu_req   = (state == EU_REQ);
    assign busy     = (state != IDLE_REQ) && (state != WAIT_ACK);

    // start pulses last the single dispatch cycle
    assign ldst_start = (state == DISPATCH) && (load || store);
    assign move_start = (state == DISPATCH) && move;
    assign ldst_we    = store;
    assign cnt_load   = ldst_start || move_start;
    assign cnt_init   = move ? move_line_num : ldst_line_num;

endmodule

`default_nettype wire

// ==== design/line_counter.sv ====
`timescale 1ns/10ps
`default_nettype none

module line_counter (
    input wire clk,
    input wire reset,

    // count load from the sequencer
    input wire                              load,
    input wire [accel_ctrl_pkg::LINE_W-1:0] init,

    // one completed line
    input wire step,

    output logic zero
);
    import accel_ctrl_pkg::*;

    logic [LINE_W-1:0] count;

    always_ff @(posedge clk) begin
        if (reset)
            count <= '0;
        else if (load)
            count <= init;
        // never wraps below zero
        else if (step && count != '0)
            count <= count - 1'b1;
    end

    // valid right after a load, zero count included
    assign zero = (count == '0);

endmodule

`default_nettype wire

// ==== design/ldst_engine.sv ====
`timescale 1ns/10ps
`default_nettype none

module ldst_engine #(
    parameter int RF_ADDR_W = 10
) (
    input wire clk,
    input wire reset,

    // command from the sequencer
    input wire                  start,
    input wire                  we,
    input wire [31:0]           sdram_addr,
    input wire [RF_ADDR_W-1:0]  rf_addr,
    input wire                  cnt_zero,
    output logic                busy,
    output logic                line_step,

    // memory handshake
    output logic                mem_req,
    output logic                mem_we,
    output logic [31:0]         mem_addr,
    output logic [31:0]         mem_wdata,
    input wire                  mem_ack,
    input wire [31:0]           mem_rdata,

    // register-file port
    output logic [RF_ADDR_W-1:0] rf_addr_out,
    output logic                 rf_we,
    output logic [31:0]          rf_wdata,
    input wire [31:0]            rf_rdata
);

    logic ack_wait;
    logic issue_line;

    // next line goes out only with ack low and lines left
    assign issue_line = busy && !mem_req && !ack_wait && !cnt_zero && !mem_ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            mem_req  <= 1'b0;
            mem_we   <= 1'b0;
            ack_wait <= 1'b0;
        end else if (start) begin
            busy   <= 1'b1;
            mem_we <= we;
        end else if (busy) begin
            if (mem_req) begin
                // drop req once the memory answers
                if (mem_ack) begin
                    mem_req  <= 1'b0;
                    ack_wait <= 1'b1;
                end
            end else if (ack_wait) begin
                if (!mem_ack)
                    ack_wait <= 1'b0;
            end else if (cnt_zero) begin
                busy <= 1'b0;
            end else if (issue_line) begin
                mem_req <= 1'b1;
            end
        end
    end

    // address pointers and store data
    always_ff @(posedge clk) begin
        if (start) begin
            mem_addr    <= sdram_addr;
            rf_addr_out <= rf_addr;
        end else if (line_step) begin
            // 16 bytes per line in sdram
            mem_addr    <= mem_addr + 32'd16;
            rf_addr_out <= rf_addr_out + 1'b1;
        end
        // held for the whole request
        if (issue_line)
            mem_wdata <= rf_rdata;
    end

    // line done when ack falls
    assign line_step = ack_wait && !mem_ack;

    // read data lands in the rf on the ack cycle
    assign rf_we    = mem_req && mem_ack && !mem_we;
    assign rf_wdata = mem_rdata;

endmodule

`default_nettype wire

// ==== design/rf_mover.sv ====
`timescale 1ns/10ps
`default_nettype none

module rf_mover #(
    parameter int RF_ADDR_W = 10
) (
    input wire clk,
    input wire reset,

    // move command
    input wire                  start,
    input wire [RF_ADDR_W-1:0]  src_addr,
    input wire [RF_ADDR_W-1:0]  dst_addr,
    input wire                  src_freeze,
    input wire                  dst_freeze,
    input wire                  cnt_zero,
    output logic                busy,
    output logic                line_step,

    // port for the load/store engine
    input wire [RF_ADDR_W-1:0]  ext_addr,
    input wire                  ext_we,
    input wire [31:0]           ext_wdata,
    output logic [31:0]         ext_rdata
);

    logic [31:0]          rf_mem [2**RF_ADDR_W];
    logic [RF_ADDR_W-1:0] src_ptr;
    logic [RF_ADDR_W-1:0] dst_ptr;
    logic                 src_frz;
    logic                 dst_frz;

    always_ff @(posedge clk) begin
        if (reset)
            busy <= 1'b0;
        else if (start)
            busy <= 1'b1;
        else if (busy && cnt_zero)
            busy <= 1'b0;
    end

    // one line per clock while lines remain
    assign line_step = busy && !cnt_zero;

    always_ff @(posedge clk) begin
        if (start) begin
            src_ptr <= src_addr;
            dst_ptr <= dst_addr;
            src_frz <= src_freeze;
            dst_frz <= dst_freeze;
        end else if (line_step) begin
            // frozen pointer stays put
            if (!src_frz)
                src_ptr <= src_ptr + 1'b1;
            if (!dst_frz)
                dst_ptr <= dst_ptr + 1'b1;
        end
    end

    // engines never run together so writes don't collide
    always_ff @(posedge clk) begin
        if (ext_we)
            rf_mem[ext_addr] <= ext_wdata;
        else if (line_step)
            rf_mem[dst_ptr] <= rf_mem[src_ptr];
    end

    // async read for store data
    assign ext_rdata = rf_mem[ext_addr];

endmodule

`default_nettype wire

// ==== design/accel_ctrl_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module accel_ctrl_top #(
    parameter int RF_ADDR_W = 10,
    parameter logic [14:0] SDRAM_OFFSET = 15'h1000
) (
    input wire clk,
    input wire reset,

    // instruction port
    output logic                              inst_req,
    input wire                                inst_ack,
    input wire [accel_isa_pkg::INST_W-1:0]    inst_data,

    // memory port
    output logic        mem_req,
    output logic        mem_we,
    output logic [31:0] mem_addr,
    output logic [31:0] mem_wdata,
    input wire          mem_ack,
    input wire [31:0]   mem_rdata,

    // execution-unit port
    output logic                                eu_req,
    output accel_isa_pkg::eu_fun_t              eu_fun,
    output logic [accel_isa_pkg::EU_UNIT_W-1:0] eu_unit,
    output logic [31:0]                         eu_fetch_addr,
    input wire                                  eu_ack,

    output logic busy
);
    import accel_isa_pkg::*;
    import accel_ctrl_pkg::*;

    logic [INST_W-1:0]    inst_word;
    logic                 load, store, move, fetch, exec;
    logic [RF_ADDR_W-1:0] ldst_rf_addr, move_src_addr, move_dst_addr;
    logic [31:0]          ldst_sdram_addr;
    logic [LINE_W-1:0]    ldst_line_num, move_line_num, cnt_init;
    logic                 move_src_freeze, move_dst_freeze;
    logic                 ldst_start, ldst_we, move_start, cnt_load, cnt_zero;
    logic                 ldst_busy, move_busy, ldst_step, move_step, cnt_step;
    logic [RF_ADDR_W-1:0] rf_addr;
    logic                 rf_we;
    logic [31:0]          rf_wdata, rf_rdata;

    inst_decode #(.RF_ADDR_W(RF_ADDR_W), .SDRAM_OFFSET(SDRAM_OFFSET)) i_inst_decode (
        .inst(inst_word), .load, .store, .move, .fetch, .exec,
        .ldst_rf_addr, .ldst_sdram_addr, .ldst_line_num,
        .move_src_addr, .move_dst_addr, .move_line_num, .move_src_freeze, .move_dst_freeze,
        .eu_unit, .eu_fetch_addr
    );

    issue_fsm i_issue_fsm (
        .clk, .reset, .inst_req, .inst_ack, .inst_data, .inst_word,
        .load, .store, .move, .fetch, .exec, .ldst_line_num, .move_line_num,
        .cnt_zero, .ldst_busy, .move_busy, .ldst_start, .ldst_we, .move_start,
        .cnt_load, .cnt_init, .eu_req, .eu_ack, .eu_fun, .busy
    );

    // only one engine is ever stepping
    assign cnt_step = ldst_step | move_step;

    line_counter i_line_counter (
        .clk, .reset, .load(cnt_load), .init(cnt_init), .step(cnt_step), .zero(cnt_zero)
    );

    ldst_engine #(.RF_ADDR_W(RF_ADDR_W)) i_ldst_engine (
        .clk, .reset, .start(ldst_start), .we(ldst_we), .sdram_addr(ldst_sdram_addr),
        .rf_addr(ldst_rf_addr), .cnt_zero, .busy(ldst_busy), .line_step(ldst_step),
        .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_ack, .mem_rdata,
        .rf_addr_out(rf_addr), .rf_we, .rf_wdata, .rf_rdata
    );

    rf_mover #(.RF_ADDR_W(RF_ADDR_W)) i_rf_mover (
        .clk, .reset, .start(move_start), .src_addr(move_src_addr), .dst_addr(move_dst_addr),
        .src_freeze(move_src_freeze), .dst_freeze(move_dst_freeze), .cnt_zero,
        .busy(move_busy), .line_step(move_step),
        .ext_addr(rf_addr), .ext_we(rf_we), .ext_wdata(rf_wdata), .ext_rdata(rf_rdata)
    );

endmodule

`default_nettype wire

// ==== test/tb_accel_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_accel_ctrl;
    import accel_isa_pkg::*;
    import accel_ctrl_pkg::*;

    localparam int TIMEOUT = 2000;
    localparam logic [14:0] OFFSET = 15'h1000;
    localparam int RF_MASK = 1023;

    logic        clk;
    logic        reset;
    logic        inst_req;
    logic        inst_ack;
    logic [31:0] inst_data;
    logic        mem_req;
    logic        mem_we;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic        mem_ack;
    logic [31:0] mem_rdata;
    logic        eu_req;
    eu_fun_t     eu_fun;
    logic [4:0]  eu_unit;
    logic [31:0] eu_fetch_addr;
    logic        eu_ack;
    logic        busy;

    accel_ctrl_top i_accel_ctrl_top (.*);

    // instruction source state
    logic [31:0] inst_list [$];
    int          inst_rd;
    int          inst_dly;
    int          mem_dly;
    int          eu_dly;

    // sdram contents, handshake logs and expected logs
    logic [31:0] sdram [logic [31:0]];
    logic [31:0] log_addr [$];
    logic [31:0] log_data [$];
    logic        log_we [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic        exp_we [$];
    logic [63:0] eu_log [$];
    logic [63:0] eu_exp [$];

    // reference register file
    logic [31:0] rf_exp [int];

    int errors;
    int tests;
    int failed;
    int test_start_errors;

    // previous-sample copies for the handshake checks
    logic        p_inst_req;
    logic        p_mem_req;
    logic        p_mem_we;
    logic [31:0] p_mem_addr;
    logic [31:0] p_mem_wdata;
    logic        p_eu_req;
    eu_fun_t     p_eu_fun;
    logic [4:0]  p_eu_unit;
    logic [31:0] p_eu_addr;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // unwritten sdram returns a pattern of the whole address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        if (sdram.exists(addr))
            return sdram[addr];
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5a3c_96e1;
    endfunction

    function automatic logic [31:0] rf_get(input int a);
        if (rf_exp.exists(a))
            return rf_exp[a];
        return 'x;
    endfunction

    task automatic value_error(input string sig, input logic [63:0] got, input logic [63:0] want);
        $display("error: %s is %h, expected %h", sig, got, want);
        errors++;
    endtask

    task automatic note_error(input string what);
        $display("failure: %s", what);
        errors++;
    endtask

    // instruction source, one word per four-phase cycle
    always @(negedge clk) begin
        if (reset) begin
            inst_ack <= 1'b0;
            inst_dly <= 0;
        end else if (inst_dly != 0) begin
            inst_dly <= inst_dly - 1;
        end else if (!inst_ack && inst_req && inst_rd < inst_list.size()) begin
            inst_data <= inst_list[inst_rd];
            inst_rd   <= inst_rd + 1;
            inst_ack  <= 1'b1;
            inst_dly  <= $urandom_range(0, 5);
        end else if (inst_ack && !inst_req) begin
            inst_ack <= 1'b0;
            inst_dly <= $urandom_range(0, 5);
        end
    end

    // sdram model, logs every handshake
    always @(negedge clk) begin
        if (reset) begin
            mem_ack <= 1'b0;
            mem_dly <= 0;
        end else if (mem_dly != 0) begin
            mem_dly <= mem_dly - 1;
        end else if (mem_req && !mem_ack) begin
            log_addr.push_back(mem_addr);
            log_we.push_back(mem_we);
            log_data.push_back(mem_we ? mem_wdata : mem_word(mem_addr));
            if (mem_we)
                sdram[mem_addr] = mem_wdata;
            mem_rdata <= mem_word(mem_addr);
            mem_ack   <= 1'b1;
            mem_dly   <= $urandom_range(0, 5);
        end else if (mem_ack && !mem_req) begin
            mem_ack <= 1'b0;
            mem_dly <= $urandom_range(0, 5);
        end
    end

    // execution unit responder
    always @(negedge clk) begin
        if (reset) begin
            eu_ack <= 1'b0;
            eu_dly <= 0;
        end else if (eu_dly != 0) begin
            eu_dly <= eu_dly - 1;
        end else if (eu_req && !eu_ack) begin
            eu_log.push_back({26'h0, eu_fun, eu_unit, eu_fetch_addr});
            eu_ack <= 1'b1;
            eu_dly <= $urandom_range(0, 5);
        end else if (eu_ack && !eu_req) begin
            eu_ack <= 1'b0;
            eu_dly <= $urandom_range(0, 5);
        end
    end

    // four-phase rules on all three ports
    always @(negedge clk) begin
        if (!reset) begin
            assert (!(inst_req && !p_inst_req && inst_ack))
                else note_error("inst_req rose while inst_ack was still high");
            assert (!(mem_req && !p_mem_req && mem_ack))
                else note_error("mem_req rose while mem_ack was still high");
            assert (!(eu_req && !p_eu_req && eu_ack))
                else note_error("eu_req rose while eu_ack was still high");
            if (p_mem_req && mem_req) begin
                assert (mem_addr == p_mem_addr)
                    else value_error("mem_addr", mem_addr, p_mem_addr);
                assert (mem_we == p_mem_we)
                    else value_error("mem_we", mem_we, p_mem_we);
                assert (mem_wdata == p_mem_wdata)
                    else value_error("mem_wdata", mem_wdata, p_mem_wdata);
            end
            if (p_eu_req && eu_req) begin
                assert (eu_fun == p_eu_fun)
                    else value_error("eu_fun", eu_fun, p_eu_fun);
                assert (eu_unit == p_eu_unit)
                    else value_error("eu_unit", eu_unit, p_eu_unit);
                assert (eu_fetch_addr == p_eu_addr)
                    else value_error("eu_fetch_addr", eu_fetch_addr, p_eu_addr);
            end
        end
        p_inst_req  <= inst_req;
        p_mem_req   <= mem_req;
        p_mem_we    <= mem_we;
        p_mem_addr  <= mem_addr;
        p_mem_wdata <= mem_wdata;
        p_eu_req    <= eu_req;
        p_eu_fun    <= eu_fun;
        p_eu_unit   <= eu_unit;
        p_eu_addr   <= eu_fetch_addr;
    end

    task automatic check_logs();
        assert (log_addr.size() == exp_addr.size())
            else value_error("memory handshake count", log_addr.size(), exp_addr.size());
        for (int i = 0; i < exp_addr.size() && i < log_addr.size(); i++) begin
            assert (log_addr[i] == exp_addr[i])
                else value_error("mem_addr", log_addr[i], exp_addr[i]);
            assert (log_we[i] == exp_we[i])
                else value_error("mem_we", log_we[i], exp_we[i]);
            assert (log_data[i] === exp_data[i])
                else value_error(exp_we[i] ? "mem_wdata" : "mem_rdata", log_data[i], exp_data[i]);
        end
        assert (eu_log.size() == eu_exp.size())
            else value_error("eu handshake count", eu_log.size(), eu_exp.size());
        for (int i = 0; i < eu_exp.size() && i < eu_log.size(); i++) begin
            assert (eu_log[i] == eu_exp[i])
                else value_error("eu_fun,eu_unit,eu_fetch_addr", eu_log[i], eu_exp[i]);
        end
        exp_addr.delete();
        exp_we.delete();
        exp_data.delete();
        eu_exp.delete();
    endtask

    // hand one word to the source, wait for the next inst_req rise
    task automatic run_inst(input logic [31:0] word);
        int n;
        log_addr.delete();
        log_we.delete();
        log_data.delete();
        eu_log.delete();
        @(posedge clk);
        inst_list.push_back(word);
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!(inst_rd == inst_list.size() && inst_req && !inst_ack) && n < TIMEOUT);
        if (n >= TIMEOUT) begin
            $display("timeout: instruction %h did not complete in %0d cycles", word, TIMEOUT);
            $display("** FAIL **");
            $finish;
        end else begin
            check_logs();
        end
    endtask

    // load or store, with the sdram line stride of 16 bytes
    task automatic ldst_cmd(input logic st, input logic [8:0] rf, input logic [12:0] idx,
                            input logic [LINE_W-1:0] n);
        logic [31:0] a;
        logic [1:0]  op;
        int          r;
        op = st ? OP_STORE : OP_LOAD;
        for (int i = 0; i < n; i++) begin
            a = {OFFSET, idx, 4'h0} + 32'(16 * i);
            r = (int'(rf) + i) & RF_MASK;
            exp_addr.push_back(a);
            exp_we.push_back(st);
            if (st) begin
                exp_data.push_back(rf_get(r));
            end else begin
                exp_data.push_back(mem_word(a));
                rf_exp[r] = mem_word(a);
            end
        end
        run_inst({op, rf, idx, n});
    endtask

    // frozen pointers stay on their first address
    task automatic move_cmd(input logic [9:0] src, input logic [9:0] dst, input logic fs,
                            input logic fd, input logic [LINE_W-1:0] n);
        int s;
        int d;
        for (int i = 0; i < n; i++) begin
            s = (int'(src) + (fs ? 0 : i)) & RF_MASK;
            d = (int'(dst) + (fd ? 0 : i)) & RF_MASK;
            rf_exp[d] = rf_get(s);
        end
        run_inst({OP_MOVE, src, dst, fs, fd, n});
    endtask

    task automatic eu_cmd(input eu_fun_t fun, input logic [4:0] unit, input logic [23:0] addr);
        eu_exp.push_back({26'h0, fun, unit, 4'h0, addr, 4'h0});
        run_inst({OP_FETCH_EXEC, fun, unit, addr});
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_start_errors) begin
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: %0d errors", name, errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    initial begin
        logic [8:0] a;
        logic [9:0] b;
        int         kind;
        int         n;
        void'($urandom(83));
        reset     = 1'b1;
        inst_ack  = 1'b0;
        inst_data = '0;
        mem_ack   = 1'b0;
        mem_rdata = '0;
        eu_ack    = 1'b0;
        inst_rd   = 0;
        errors    = 0;
        tests     = 0;
        failed    = 0;
        test_start_errors = 0;
        repeat (16) @(negedge clk);
        assert (!inst_req && !mem_req && !eu_req && !busy)
            else note_error("a request output or busy is high under reset");
        reset = 1'b0;
        end_test("reset state");

        for (int i = 0; i < 4; i++)
            sdram[{OFFSET, 13'h020, 4'h0} + 32'(16 * i)] = $urandom;
        ldst_cmd(1'b0, 9'd5, 13'h020, 8'd4);
        ldst_cmd(1'b1, 9'd5, 13'h100, 8'd4);
        end_test("load then store");

        move_cmd(10'd5, 10'd40, 1'b0, 1'b0, 8'd3);
        ldst_cmd(1'b1, 9'd40, 13'h200, 8'd3);
        end_test("move");

        move_cmd(10'd5, 10'd80, 1'b1, 1'b0, 8'd3);
        ldst_cmd(1'b1, 9'd80, 13'h300, 8'd3);
        move_cmd(10'd5, 10'd120, 1'b0, 1'b1, 8'd3);
        ldst_cmd(1'b1, 9'd120, 13'h310, 8'd1);
        end_test("freeze bits");

        eu_cmd(EU_FETCH, 5'd3, 24'h123456);
        eu_cmd(EU_EXEC, 5'd17, 24'habcdef);
        end_test("fetch and exec");

        // nothing moves, so the final store still sees the move result
        ldst_cmd(1'b0, 9'd40, 13'h500, 8'd0);
        ldst_cmd(1'b1, 9'd40, 13'h400, 8'd0);
        move_cmd(10'd5, 10'd41, 1'b0, 1'b0, 8'd0);
        ldst_cmd(1'b1, 9'd40, 13'h208, 8'd3);
        end_test("zero lines");

        // random ops stay inside a fully loaded rf window
        ldst_cmd(1'b0, 9'd0, 13'h800, 8'd64);
        repeat (30) begin
            kind = $urandom_range(0, 3);
            n    = $urandom_range(0, 6);
            a    = 9'($urandom_range(0, 63 - n));
            b    = 10'($urandom_range(0, 63 - n));
            case (kind)
                0: ldst_cmd(1'b0, a, 13'($urandom), 8'(n));
                1: ldst_cmd(1'b1, a, 13'($urandom), 8'(n));
                2: move_cmd(10'(a), b, 1'($urandom), 1'($urandom), 8'(n));
                default: eu_cmd(eu_fun_t'($urandom_range(0, 1)), 5'($urandom), 24'($urandom));
            endcase
        end
        end_test("random mix");

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
design/accel_isa_pkg.sv
design/accel_ctrl_pkg.sv
design/inst_decode.sv
design/issue_fsm.sv
design/line_counter.sv
design/ldst_engine.sv
design/rf_mover.sv
design/accel_ctrl_top.sv
test/tb_accel_ctrl.sv
